/* verification/decode_exec_patterns.hex */
// Columns: inst pc stall exec_type rd value taken context
// One record per line; stall 1 starts a random exec_stall burst, an all-zero record ends the list
007302B3 00000100 00000000 000000C0 00000005 00000000 00000000 00000000
06400093 00000104 00000000 00000040 00000001 00000064 00000000 00000000
FF900113 00000108 00000000 00000040 00000002 FFFFFFF9 00000000 00000000
002081B3 0000010C 00000001 000000C0 00000003 0000005D 00000000 00000000
40208233 00000110 00000000 000000C0 00000004 0000006B 00000000 00000000
40115333 00000114 00000000 000000C0 00000006 FFFFFFFF 00000000 00000000
001123B3 00000118 00000000 000000C0 00000007 00000001 00000000 00000000
00113433 0000011C 00000000 000000C0 00000008 00000000 00000000 00000000
40115493 00000120 00000000 00000040 00000009 FFFFFFFC 00000000 00000000
0FF0C513 00000124 00000000 00000040 0000000A 0000009B 00000000 00000000
0030858B 00000128 00000000 00000080 0000000B 00002454 00000000 00000000
0011160B 0000012C 00000000 00000080 0000000C FFFFFFF9 00000000 00000000
0011368B 00000130 00000000 00000080 0000000D 00000064 00000000 00000000
12345737 00000134 00000001 00000002 0000000E 12345000 00000000 00000000
00001797 00000138 00000000 00000002 0000000F 00001138 00000000 00000000
0080086F 0000013C 00000000 00000008 00000010 00000140 00000000 00000000
000088E7 00000140 00000000 00000008 00000011 00000144 00000000 00000000
0080A903 00000144 00000000 00000010 00000012 0000006C 00000000 00000000
FE30AE23 00000148 00000000 00000010 0000001C 00000060 00000000 00000000
00208A53 0000014C 00000000 00000020 00000014 00000000 00000000 00000000
00019AAB 00000150 00000000 00000001 00000015 0000005D 00000000 00000000
014A8B33 00000154 00000000 000000C0 00000016 0000005D 00000000 00000000
00508013 00000158 00000000 00000040 00000000 00000069 00000000 00000000
00000BAB 0000015C 00000000 00000001 00000017 00000000 00000000 00000000
00108463 00000160 00000000 00000004 00000008 00000000 00000001 00000001
00109463 00000164 00000000 00000004 00000008 00000000 00000000 00000004
00114463 00000168 00000001 00000004 00000008 00000000 00000001 00000005
00115463 0000016C 00000000 00000004 00000008 00000000 00000000 00000008
00116463 00000170 00000000 00000004 00000008 00000000 00000000 0000000A
00117463 00000174 00000000 00000004 00000008 00000000 00000001 0000000B
00040463 00000178 00000000 00000004 00000008 00000000 00000001 0000000D
00419463 0000017C 00000000 00000004 00000008 00000000 00000001 0000000F
0020C463 00000180 00000000 00000004 00000008 00000000 00000000 00000002
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000

/* decode_exec_top.f */
src/exec_info_pkg.sv
src/instr_decoder.sv
src/branch_context_tracker.sv
src/dec_exec_queue.sv
src/exec_unit.sv
src/decode_exec_top.sv
verification/decode_exec_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator and run it from the project root
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
    -f decode_exec_top.f \
    --top-module decode_exec_tb \
    -o decode_exec_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/decode_exec_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qxF -- ">>> PASS"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

/* verification/decode_exec_tb.sv */
`timescale 1ns/1ps

module decode_exec_tb;

    localparam int CLK_PERIOD     = 4;
    localparam int RESET_CYCLES   = 10;
    localparam int REC_WORDS      = 8;
    localparam int MAX_RECORDS    = 64;
    localparam int CYCLES_PER_REC = 40;

    // Word positions inside one pattern record
    localparam int F_INST    = 0;
    localparam int F_PC      = 1;
    localparam int F_STALL   = 2;
    localparam int F_TYPE    = 3;
    localparam int F_RD      = 4;
    localparam int F_VALUE   = 5;
    localparam int F_TAKEN   = 6;
    localparam int F_CONTEXT = 7;

    logic                      clk;
    logic                      reset;
    logic                      inst_valid;
    exec_info_pkg::word_t      inst;
    exec_info_pkg::pc_t        inst_pc;
    logic                      exec_stall;
    logic                      queue_full;
    logic                      res_valid;
    exec_info_pkg::exec_type_t res_exec_type;
    exec_info_pkg::reg_idx_t   res_rd;
    exec_info_pkg::word_t      res_value;
    logic                      res_taken;
    exec_info_pkg::context_t   res_context;

    logic [31:0] patterns [MAX_RECORDS * REC_WORDS];
    int          num_records;
    int          res_count;
    logic        records_ready;

    decode_exec_top #(
        .QUEUE_DEPTH (exec_info_pkg::QUEUE_DEPTH)
    ) u_decode_exec_top (
        .clk           (clk),
        .reset         (reset),
        .inst_valid    (inst_valid),
        .inst          (inst),
        .inst_pc       (inst_pc),
        .exec_stall    (exec_stall),
        .queue_full    (queue_full),
        .res_valid     (res_valid),
        .res_exec_type (res_exec_type),
        .res_rd        (res_rd),
        .res_value     (res_value),
        .res_taken     (res_taken),
        .res_context   (res_context)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] pattern_field(input int rec, input int idx);
        return patterns[rec * REC_WORDS + idx];
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("FAIL time %0t ns: %s is %h, expected %h", $time, name, got, expected);
            $display(">>> FAIL");
            $fatal(1);
        end
    endtask

    // Results are compared in issue order, sampled mid-cycle
    always @(negedge clk) begin
        if (!reset && res_valid === 1'b1) begin
            if (res_count >= num_records) begin
                $display("Result seen after the last expected record at time %0t ns", $time);
                $display(">>> FAIL");
                $fatal(1);
            end else begin
                check_value("res_exec_type", 32'(res_exec_type), pattern_field(res_count, F_TYPE));
                check_value("res_rd", 32'(res_rd), pattern_field(res_count, F_RD));
                check_value("res_value", res_value, pattern_field(res_count, F_VALUE));
                check_value("res_taken", 32'(res_taken), pattern_field(res_count, F_TAKEN));
                check_value("res_context", 32'(res_context),
                            pattern_field(res_count, F_CONTEXT));
                res_count = res_count + 1;
            end
        end
    end

    initial begin
        wait (records_ready === 1'b1);
        #((num_records * CYCLES_PER_REC + RESET_CYCLES) * CLK_PERIOD);
        $display("Timeout: only %0d of %0d results arrived", res_count, num_records);
        $display(">>> FAIL");
        $fatal(1);
    end

    initial begin
        int   stall_left;
        int   issue_idx;
        logic full_seen;
        clk           = 1'b0;
        reset         = 1'b1;
        inst_valid    = 1'b0;
        inst          = '0;
        inst_pc       = '0;
        exec_stall    = 1'b0;
        res_count     = 0;
        num_records   = 0;
        records_ready = 1'b0;
        stall_left    = 0;
        issue_idx     = 0;
        full_seen     = 1'b0;
        void'($urandom(32'h286cd863));

        $readmemh("verification/decode_exec_patterns.hex", patterns);
        while (num_records < MAX_RECORDS && pattern_field(num_records, F_INST) !== '0
               && !$isunknown(pattern_field(num_records, F_INST))) begin
            num_records++;                         // All-zero record ends the list
        end
        if (num_records == 0) begin
            $display("No records could be read from the patterns file");
            $display(">>> FAIL");
            $fatal(1);
        end
        records_ready = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset = 1'b0;
        @(negedge clk);
        check_value("res_valid", 32'(res_valid), 32'd0);
        check_value("queue_full", 32'(queue_full), 32'd0);

        while (res_count < num_records) begin
            @(posedge clk);
            #1;
            inst_valid = 1'b0;
            exec_stall = (stall_left > 0);
            if (stall_left > 0) stall_left--;
            if (queue_full) full_seen = 1'b1;
            if (issue_idx < num_records && !queue_full) begin
                inst_valid = 1'b1;
                inst       = pattern_field(issue_idx, F_INST);
                inst_pc    = pattern_field(issue_idx, F_PC);
                if (pattern_field(issue_idx, F_STALL) != 0) begin
                    exec_stall = 1'b1;
                    stall_left = 4 + int'($urandom % 4);   // Stall of 5 to 8 cycles
                end
                issue_idx++;
            end
        end

        inst_valid = 1'b0;
        exec_stall = 1'b0;
        check_value("queue_full_seen", 32'(full_seen), 32'd1);
        repeat (4) @(posedge clk);                 // Catch any stray result
        $display(">>> PASS");
        $finish;
    end

endmodule

/* src/decode_exec_top.sv */
`timescale 1ns/1ps

module decode_exec_top #(
    parameter int QUEUE_DEPTH = exec_info_pkg::QUEUE_DEPTH
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      inst_valid,
    input  exec_info_pkg::word_t      inst,
    input  exec_info_pkg::pc_t        inst_pc,
    input  logic                      exec_stall,
    output logic                      queue_full,
    output logic                      res_valid,
    output exec_info_pkg::exec_type_t res_exec_type,
    output exec_info_pkg::reg_idx_t   res_rd,
    output exec_info_pkg::word_t      res_value,
    output logic                      res_taken,
    output exec_info_pkg::context_t   res_context
);

    logic branch, empty, pop;
    exec_info_pkg::context_t       b_t_context, b_f_context;
    exec_info_pkg::dec_exec_info_t dec_exec_info, head_info;
    exec_info_pkg::pc_t            head_pc;

    instr_decoder u_instr_decoder (
        .inst          (inst),
        .branch        (branch),
        .b_t_context   (b_t_context),
        .b_f_context   (b_f_context),
        .dec_exec_info (dec_exec_info)
    );

    branch_context_tracker u_branch_context_tracker (
        .clk         (clk),
        .reset       (reset),
        .alloc       (inst_valid & branch),    // Only accepted branches allocate
        .b_t_context (b_t_context),
        .b_f_context (b_f_context)
    );

    dec_exec_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_dec_exec_queue (
        .clk       (clk),
        .reset     (reset),
        .push      (inst_valid),
        .push_info (dec_exec_info),
        .push_pc   (inst_pc),
        .pop       (pop),
        .head_info (head_info),
        .head_pc   (head_pc),
        .empty     (empty),
        .full      (queue_full)
    );

    exec_unit u_exec_unit (
        .clk           (clk),
        .reset         (reset),
        .head_info     (head_info),
        .head_pc       (head_pc),
        .empty         (empty),
        .exec_stall    (exec_stall),
        .pop           (pop),
        .res_valid     (res_valid),
        .res_exec_type (res_exec_type),
        .res_rd        (res_rd),
        .res_value     (res_value),
        .res_taken     (res_taken),
        .res_context   (res_context)
    );

endmodule

/* src/exec_unit.sv */
`timescale 1ns/1ps

module exec_unit (
    input  logic                          clk,
    input  logic                          reset,
    input  exec_info_pkg::dec_exec_info_t head_info,
    input  exec_info_pkg::pc_t            head_pc,
    input  logic                          empty,
    input  logic                          exec_stall,
    output logic                          pop,
    output logic                          res_valid,
    output exec_info_pkg::exec_type_t     res_exec_type,
    output exec_info_pkg::reg_idx_t       res_rd,
    output exec_info_pkg::word_t          res_value,
    output logic                          res_taken,
    output exec_info_pkg::context_t       res_context
);

    exec_info_pkg::exec_type_t exec_type;
    exec_info_pkg::inst_vreg_t inst_vreg;
    exec_info_pkg::word_t      d_imm;
    exec_info_pkg::func3_t     func3;
    exec_info_pkg::func7_t     func7;
    exec_info_pkg::context_t   b_t_context, b_f_context, ctx_sel;
    exec_info_pkg::reg_idx_t   rd, rs1, rs2;
    exec_info_pkg::word_t      rs1_val, rs2_val, alu_b, result;
    exec_info_pkg::word_t      regfile [32];
    logic alu, alu_std, alu_imm, alu_ext;
    logic mem, jump, branch, subst, io;
    logic alt, taken, wr_en;

    function automatic exec_info_pkg::word_t alu_op(input exec_info_pkg::func3_t f3,
            input logic alt_op, input exec_info_pkg::word_t a, input exec_info_pkg::word_t b);
        case (f3)
            3'b000:  return alt_op ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt_op ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // Custom-0 extension set
    function automatic exec_info_pkg::word_t ext_op(input exec_info_pkg::func3_t f3,
            input logic alt_op, input exec_info_pkg::word_t a, input exec_info_pkg::word_t b);
        logic [63:0] prod;
        prod = a * b;
        case (f3)
            3'b000:  return alt_op ? prod[63:32] : prod[31:0];
            3'b001:  return ($signed(a) < $signed(b)) ? a : b;
            3'b010:  return ($signed(a) < $signed(b)) ? b : a;
            3'b011:  return (a < b) ? a : b;
            3'b100:  return (a < b) ? b : a;
            3'b101:  return a & ~b;
            3'b110:  return a | ~b;
            default: return ~(a ^ b);
        endcase
    endfunction

    function automatic logic branch_cmp(input exec_info_pkg::func3_t f3,
            input exec_info_pkg::word_t a, input exec_info_pkg::word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    assign exec_type   = head_info[exec_info_pkg::OFS_EXEC_TYPE +: exec_info_pkg::LEN_EXEC_TYPE];
    assign inst_vreg   = head_info[exec_info_pkg::OFS_INST_VREG +: exec_info_pkg::LEN_INST_VREG];
    assign d_imm       = head_info[exec_info_pkg::OFS_D_IMM +: exec_info_pkg::LEN_WORD];
    assign func3       = head_info[exec_info_pkg::OFS_FUNC3 +: exec_info_pkg::LEN_FUNC3];
    assign func7       = head_info[exec_info_pkg::OFS_FUNC7 +: exec_info_pkg::LEN_FUNC7];
    assign b_t_context = head_info[exec_info_pkg::OFS_B_T_CONTEXT +: exec_info_pkg::LEN_CONTEXT];
    assign b_f_context = head_info[exec_info_pkg::OFS_B_F_CONTEXT +: exec_info_pkg::LEN_CONTEXT];

    assign {rd, rs1, rs2} = inst_vreg;

    assign alu     = exec_type[exec_info_pkg::EXEC_BIT_ALU_NON_IMM]
                   | exec_type[exec_info_pkg::EXEC_BIT_ALU_NON_EXT];
    assign alu_std = exec_type[exec_info_pkg::EXEC_BIT_ALU_NON_IMM]
                   & exec_type[exec_info_pkg::EXEC_BIT_ALU_NON_EXT];
    assign alu_imm = exec_type[exec_info_pkg::EXEC_BIT_ALU_NON_EXT]
                   & ~exec_type[exec_info_pkg::EXEC_BIT_ALU_NON_IMM];
    assign alu_ext = exec_type[exec_info_pkg::EXEC_BIT_ALU_NON_IMM]
                   & ~exec_type[exec_info_pkg::EXEC_BIT_ALU_NON_EXT];
    assign mem     = exec_type[exec_info_pkg::EXEC_BIT_MEM];
    assign jump    = exec_type[exec_info_pkg::EXEC_BIT_JUMP];
    assign branch  = exec_type[exec_info_pkg::EXEC_BIT_BRANCH];
    assign subst   = exec_type[exec_info_pkg::EXEC_BIT_SUBST];
    assign io      = exec_type[exec_info_pkg::EXEC_BIT_IO];

    assign rs1_val = regfile[rs1];                 // x0 is never written
    assign rs2_val = regfile[rs2];
    assign alu_b   = alu_std ? rs2_val : d_imm;
    assign alt     = func7[5] & (~alu_imm | (func3 == 3'b101)); // Only SRAI has alt in imm form

    always_comb begin
        result  = '0;                              // FPU results stay zero
        taken   = 1'b0;
        ctx_sel = '0;
        if (alu) begin
            result = alu_ext ? ext_op(func3, alt, rs1_val, rs2_val)
                             : alu_op(func3, alt, rs1_val, alu_b);
        end else if (subst) begin
            result = (func3 == exec_info_pkg::SUBST_F3_AUIPC) ? head_pc + d_imm : d_imm;
        end else if (jump) begin
            result = head_pc + 32'd4;
        end else if (mem) begin
            result = rs1_val + d_imm;              // Address only
        end else if (io) begin
            result = rs1_val;
        end else if (branch) begin
            taken   = branch_cmp(func3, rs1_val, rs2_val);
            ctx_sel = taken ? b_t_context : b_f_context;
        end
    end

    assign pop   = ~empty & ~exec_stall;
    assign wr_en = pop & (alu | subst | jump | io) & (rd != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regfile[i] <= '0;
            end
        end else if (wr_en) begin
            regfile[rd] <= result;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            res_exec_type <= exec_type;
            res_rd        <= rd;
            res_value     <= result;
            res_taken     <= taken;
            res_context   <= ctx_sel;
        end
    end

endmodule

/* src/dec_exec_queue.sv */
`timescale 1ns/1ps

module dec_exec_queue #(
    parameter int QUEUE_DEPTH = exec_info_pkg::QUEUE_DEPTH
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          push,
    input  exec_info_pkg::dec_exec_info_t push_info,
    input  exec_info_pkg::pc_t            push_pc,
    input  logic                          pop,
    output exec_info_pkg::dec_exec_info_t head_info,
    output exec_info_pkg::pc_t            head_pc,
    output logic                          empty,
    output logic                          full
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    exec_info_pkg::dec_exec_info_t info_mem [QUEUE_DEPTH];
    exec_info_pkg::pc_t            pc_mem   [QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr, rd_ptr;
    logic [CNT_W-1:0] count;
    logic do_push, do_pop;

    assign empty   = (count == '0);
    assign full    = (count == CNT_W'(QUEUE_DEPTH));
    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    assign head_info = info_mem[rd_ptr];
    assign head_pc   = pc_mem[rd_ptr];

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
    endfunction

    always_ff @(posedge clk) begin
        if (do_push) begin
            info_mem[wr_ptr] <= push_info;
            pc_mem[wr_ptr]   <= push_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)  rd_ptr <= next_ptr(rd_ptr);
            count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

endmodule

/* src/branch_context_tracker.sv */
`timescale 1ns/1ps

module branch_context_tracker (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    alloc,
    output exec_info_pkg::context_t b_t_context,
    output exec_info_pkg::context_t b_f_context
);

    exec_info_pkg::context_t ctx;

    // Two contexts per branch, wrapping modulo 16
    assign b_t_context = ctx + exec_info_pkg::context_t'(1);
    assign b_f_context = ctx + exec_info_pkg::context_t'(2);

    always_ff @(posedge clk) begin
        if (reset) begin
            ctx <= '0;
        end else if (alloc) begin
            ctx <= b_f_context;                    // Next free pair starts here
        end
    end

endmodule

/* src/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder (
    input  exec_info_pkg::word_t          inst,
    output logic                          branch,
    input  exec_info_pkg::context_t       b_t_context,
    input  exec_info_pkg::context_t       b_f_context,
    output exec_info_pkg::dec_exec_info_t dec_exec_info
);

    localparam logic [6:0] OPC_OP      = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM  = 7'b0010011;
    localparam logic [6:0] OPC_CUSTOM0 = 7'b0001011;
    localparam logic [6:0] OPC_LOAD    = 7'b0000011;
    localparam logic [6:0] OPC_STORE   = 7'b0100011;
    localparam logic [6:0] OPC_JAL     = 7'b1101111;
    localparam logic [6:0] OPC_JALR    = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH  = 7'b1100011;
    localparam logic [6:0] OPC_LUI     = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC   = 7'b0010111;
    localparam logic [6:0] OPC_OP_FP   = 7'b1010011;
    localparam logic [6:0] OPC_CUSTOM1 = 7'b0101011;

    logic [6:0] opcode;
    logic alu_non_imm, alu_non_ext, fpu, mem, jump, subst, io;
    logic io_type;
    exec_info_pkg::exec_type_t exec_type;
    exec_info_pkg::inst_vreg_t inst_vreg;
    exec_info_pkg::word_t imm_i, imm_s, imm_b, imm_u, imm_j, d_imm;
    exec_info_pkg::func3_t func3;
    exec_info_pkg::func7_t func7;

    assign opcode = inst[6:0];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        alu_non_imm = 1'b0;
        alu_non_ext = 1'b0;
        fpu         = 1'b0;
        mem         = 1'b0;
        jump        = 1'b0;
        branch      = 1'b0;
        subst       = 1'b0;
        io          = 1'b0;
        d_imm       = imm_i;                       // I format unless stated
        func3       = inst[14:12];
        case (opcode)
            OPC_OP: begin
                alu_non_imm = 1'b1;
                alu_non_ext = 1'b1;
            end
            OPC_OP_IMM:  alu_non_ext = 1'b1;
            OPC_CUSTOM0: alu_non_imm = 1'b1;       // Extension ops, register form
            OPC_LOAD:    mem = 1'b1;
            OPC_STORE: begin
                mem   = 1'b1;
                d_imm = imm_s;
            end
            OPC_JAL: begin
                jump  = 1'b1;
                d_imm = imm_j;
            end
            OPC_JALR:    jump = 1'b1;
            OPC_BRANCH: begin
                branch = 1'b1;
                d_imm  = imm_b;
            end
            OPC_LUI: begin
                subst = 1'b1;
                d_imm = imm_u;
                func3 = exec_info_pkg::SUBST_F3_LUI;
            end
            OPC_AUIPC: begin
                subst = 1'b1;
                d_imm = imm_u;
                func3 = exec_info_pkg::SUBST_F3_AUIPC;
            end
            OPC_OP_FP:   fpu = 1'b1;
            OPC_CUSTOM1: io = 1'b1;
            default: ;                             // Unknown opcode decodes to no type
        endcase
    end

    assign io_type   = io & inst[12];
    assign func7     = inst[31:25];
    assign inst_vreg = {inst[11:7], inst[19:15], inst[24:20]};
    assign exec_type = {alu_non_imm, alu_non_ext, fpu, mem, jump, branch, subst, io};

    assign dec_exec_info = {exec_type, inst_vreg, d_imm, io_type,
                            func3, func7, b_t_context, b_f_context};

endmodule

/* src/exec_info_pkg.sv */
package exec_info_pkg;

    localparam int LEN_WORD      = 32;
    localparam int LEN_EXEC_TYPE = 8;
    localparam int LEN_REG       = 5;
    localparam int LEN_INST_VREG = 3 * LEN_REG;                  // rd, rs1, rs2
    localparam int LEN_FUNC3     = 3;
    localparam int LEN_FUNC7     = 7;
    localparam int LEN_CONTEXT   = 4;

    localparam int LEN_D_E_INFO  = LEN_EXEC_TYPE + LEN_INST_VREG + LEN_WORD + 1
                                 + LEN_FUNC3 + LEN_FUNC7 + 2 * LEN_CONTEXT;

    // Field offsets inside the bundle, counted from bit 0
    localparam int OFS_B_F_CONTEXT = 0;
    localparam int OFS_B_T_CONTEXT = OFS_B_F_CONTEXT + LEN_CONTEXT;
    localparam int OFS_FUNC7       = OFS_B_T_CONTEXT + LEN_CONTEXT;
    localparam int OFS_FUNC3       = OFS_FUNC7 + LEN_FUNC7;
    localparam int OFS_D_IMM       = OFS_FUNC3 + LEN_FUNC3 + 1;  // io_type sits below d_imm
    localparam int OFS_INST_VREG   = OFS_D_IMM + LEN_WORD;
    localparam int OFS_EXEC_TYPE   = OFS_INST_VREG + LEN_INST_VREG;

    // Execution type flag positions
    localparam int EXEC_BIT_ALU_NON_IMM = 7;
    localparam int EXEC_BIT_ALU_NON_EXT = 6;
    localparam int EXEC_BIT_FPU         = 5;
    localparam int EXEC_BIT_MEM         = 4;
    localparam int EXEC_BIT_JUMP        = 3;
    localparam int EXEC_BIT_BRANCH      = 2;
    localparam int EXEC_BIT_SUBST       = 1;
    localparam int EXEC_BIT_IO          = 0;

    localparam int QUEUE_DEPTH = 4;

    typedef logic [LEN_WORD-1:0]      word_t;
    typedef logic [LEN_WORD-1:0]      pc_t;
    typedef logic [LEN_EXEC_TYPE-1:0] exec_type_t;
    typedef logic [LEN_REG-1:0]       reg_idx_t;
    typedef logic [LEN_INST_VREG-1:0] inst_vreg_t;
    typedef logic [LEN_FUNC3-1:0]     func3_t;
    typedef logic [LEN_FUNC7-1:0]     func7_t;
    typedef logic [LEN_CONTEXT-1:0]   context_t;
    typedef logic [LEN_D_E_INFO-1:0]  dec_exec_info_t;

    // func3 carried by subst entries tells LUI from AUIPC
    localparam func3_t SUBST_F3_LUI   = 3'b000;
    localparam func3_t SUBST_F3_AUIPC = 3'b001;

endpackage
